//--- core_pkg.sv
`default_nettype none

package core_pkg;

    // Screen coordinate, wide enough for the small raster
    typedef logic [7:0] pix_t;

    // Palette index
    typedef logic [3:0] cidx_t;

    // Packed colour, red in the high byte
    typedef logic [23:0] rgb_t;

    // Pattern select
    typedef logic [1:0] mode_t;

    // Frame controller states
    typedef enum logic [1:0] {
        ST_WAIT_VS,
        ST_ACTIVE,
        ST_VBLANK
    } ctrl_state_t;

    // Horizontal raster, in pixels
    localparam int H_ACTIVE = 32;
    localparam int H_TOTAL  = 40;
    localparam int HS_START = 34;
    localparam int HS_WIDTH = 3;

    // Vertical raster, in lines
    localparam int V_ACTIVE = 24;
    localparam int V_TOTAL  = 28;
    localparam int VS_START = 25;
    localparam int VS_WIDTH = 2;

    // clk50 cycles per pixel
    localparam int CEN_DIV = 2;

endpackage

`default_nettype wire

//--- video_timing.sv
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = core_pkg::H_ACTIVE,
    parameter int H_TOTAL  = core_pkg::H_TOTAL,
    parameter int HS_START = core_pkg::HS_START,
    parameter int HS_WIDTH = core_pkg::HS_WIDTH,
    parameter int V_ACTIVE = core_pkg::V_ACTIVE,
    parameter int V_TOTAL  = core_pkg::V_TOTAL,
    parameter int VS_START = core_pkg::VS_START,
    parameter int VS_WIDTH = core_pkg::VS_WIDTH,
    parameter int CEN_DIV  = core_pkg::CEN_DIV
) (
    input  wire logic          clk50,
    input  wire logic          rst_n,
    output logic               pix_cen,
    output core_pkg::pix_t     hcount,
    output core_pkg::pix_t     vcount,
    output logic               hs_raw,
    output logic               vs_raw,
    output logic               act_raw
);

    import core_pkg::*;

    // Divider needs at least one bit even when CEN_DIV is 1
    localparam int CEN_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

    logic [CEN_W-1:0] cen_cnt;
    logic             line_end;
    logic             frame_end;

    // Pixel enable on the last clock of each pixel period
    assign pix_cen = (cen_cnt == CEN_W'(CEN_DIV - 1));

    always_ff @(posedge clk50) begin
        if (!rst_n) begin
            cen_cnt <= '0;
        end else if (pix_cen) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= cen_cnt + 1'b1;
        end
    end

    assign line_end  = (hcount == pix_t'(H_TOTAL - 1));
    assign frame_end = (vcount == pix_t'(V_TOTAL - 1));

    // Horizontal counter, steps once per pixel
    always_ff @(posedge clk50) begin
        if (!rst_n) begin
            hcount <= '0;
        end else if (pix_cen) begin
            if (line_end) begin
                hcount <= '0;
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // Vertical counter, steps at the end of each line
    always_ff @(posedge clk50) begin
        if (!rst_n) begin
            vcount <= '0;
        end else if (pix_cen && line_end) begin
            if (frame_end) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    // Sync windows decoded straight from the counters, active high
    assign hs_raw = (int'(hcount) >= HS_START) && (int'(hcount) < HS_START + HS_WIDTH);
    assign vs_raw = (int'(vcount) >= VS_START) && (int'(vcount) < VS_START + VS_WIDTH);

    // Visible area
    assign act_raw = (int'(hcount) < H_ACTIVE) && (int'(vcount) < V_ACTIVE);

endmodule

`default_nettype wire

//--- frame_ctrl.sv
`default_nettype none

module frame_ctrl (
    input  wire logic             clk50,
    input  wire logic             rst_n,
    input  wire logic             vs_raw,
    input  wire logic             act_raw,
    input  wire core_pkg::pix_t   scroll_x,
    input  wire core_pkg::mode_t  mode,
    output core_pkg::pix_t        scroll_q,
    output core_pkg::mode_t       mode_q,
    output logic                  disp_en,
    output logic [31:0]           frame_cnt,
    output logic                  led_user
);

    import core_pkg::*;

    ctrl_state_t state;
    logic        vs_prev;
    logic        vs_rise;

    // Frame boundary is the leading edge of vsync
    assign vs_rise = vs_raw && !vs_prev;

    always_ff @(posedge clk50) begin
        if (!rst_n) begin
            vs_prev <= 1'b0;
        end else begin
            vs_prev <= vs_raw;
        end
    end

    // Every vsync edge starts a blanking period, whatever the current state
    always_ff @(posedge clk50) begin
        if (!rst_n) begin
            state <= ST_WAIT_VS;
        end else if (vs_rise) begin
            state <= ST_VBLANK;
        end else begin
            case (state)
                ST_WAIT_VS: state <= ST_WAIT_VS;
                ST_VBLANK: begin
                    // First visible pixel of the new frame
                    if (act_raw) begin
                        state <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE:  state <= ST_ACTIVE;
                default:    state <= ST_WAIT_VS;
            endcase
        end
    end

    // Scroll and mode only change between frames, so no tearing
    always_ff @(posedge clk50) begin
        if (!rst_n) begin
            scroll_q  <= '0;
            mode_q    <= '0;
            frame_cnt <= '0;
        end else if (vs_rise) begin
            scroll_q  <= scroll_x;
            mode_q    <= mode;
            frame_cnt <= frame_cnt + 32'd1;
        end
    end

    // Display stays dark until the first frame boundary
    assign disp_en = (state != ST_WAIT_VS);

    // Blinks every eight frames
    assign led_user = frame_cnt[3];

endmodule

`default_nettype wire

//--- pattern_gen.sv
`default_nettype none

module pattern_gen (
    input  wire logic             clk50,
    input  wire logic             rst_n,
    input  wire core_pkg::pix_t   hcount,
    input  wire core_pkg::pix_t   vcount,
    input  wire core_pkg::pix_t   scroll_q,
    input  wire core_pkg::mode_t  mode_q,
    input  wire logic             act_raw,
    input  wire logic             hs_raw,
    input  wire logic             vs_raw,
    input  wire logic             pix_cen,
    input  wire logic             disp_en,
    output core_pkg::cidx_t       cidx,
    output logic                  de_d,
    output logic                  hs_d,
    output logic                  vs_d,
    output logic                  ce_d
);

    import core_pkg::*;

    pix_t  pos_x;
    pix_t  pos_y;
    pix_t  xy_xor;
    pix_t  xy_sum;
    cidx_t cidx_next;

    // Scroll wraps around the 8-bit coordinate space
    assign pos_x = hcount + scroll_q;
    assign pos_y = vcount;

    assign xy_xor = pos_x ^ pos_y;
    assign xy_sum = pos_x + pos_y;

    always_comb begin
        case (mode_q)
            // Vertical bars four pixels wide
            2'd0:    cidx_next = pos_x[5:2];
            // Horizontal stripes two lines high
            2'd1:    cidx_next = pos_y[4:1];
            // Checker-like XOR pattern
            2'd2:    cidx_next = xy_xor[3:0];
            // Diagonal bands
            default: cidx_next = xy_sum[3:0];
        endcase
    end

    // Registered colour index
    always_ff @(posedge clk50) begin
        cidx <= cidx_next;
    end

    // Control path delayed by the same stage as the index
    always_ff @(posedge clk50) begin
        if (!rst_n) begin
            de_d <= 1'b0;
            hs_d <= 1'b0;
            vs_d <= 1'b0;
            ce_d <= 1'b0;
        end else begin
            de_d <= act_raw && disp_en;
            hs_d <= hs_raw;
            vs_d <= vs_raw;
            ce_d <= pix_cen;
        end
    end

endmodule

`default_nettype wire

//--- color_lut.sv
`default_nettype none

module color_lut (
    input  wire logic             clk50,
    input  wire logic             rst_n,
    input  wire core_pkg::cidx_t  cidx,
    input  wire logic             de_d,
    input  wire logic             hs_d,
    input  wire logic             vs_d,
    input  wire logic             ce_d,
    input  wire logic             pal_we,
    input  wire core_pkg::cidx_t  pal_addr,
    input  wire core_pkg::rgb_t   pal_data,
    output logic [7:0]            vga_r,
    output logic [7:0]            vga_g,
    output logic [7:0]            vga_b,
    output logic                  vga_de,
    output logic                  vga_hs,
    output logic                  vga_vs,
    output logic                  vga_ce
);

    import core_pkg::*;

    rgb_t pal [16];
    rgb_t rgb;

    // Palette write port, cleared to black on reset
    always_ff @(posedge clk50) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                pal[i] <= '0;
            end
        end else if (pal_we) begin
            pal[pal_addr] <= pal_data;
        end
    end

    // Registered lookup, black outside the display enable
    always_ff @(posedge clk50) begin
        if (!rst_n) begin
            rgb    <= '0;
            vga_de <= 1'b0;
            vga_hs <= 1'b0;
            vga_vs <= 1'b0;
            vga_ce <= 1'b0;
        end else begin
            rgb    <= de_d ? pal[cidx] : '0;
            vga_de <= de_d;
            vga_hs <= hs_d;
            vga_vs <= vs_d;
            vga_ce <= ce_d;
        end
    end

    assign vga_r = rgb[23:16];
    assign vga_g = rgb[15:8];
    assign vga_b = rgb[7:0];

endmodule

`default_nettype wire

//--- retro_video_core.sv
`default_nettype none

module retro_video_core #(
    parameter int H_ACTIVE = core_pkg::H_ACTIVE,
    parameter int H_TOTAL  = core_pkg::H_TOTAL,
    parameter int HS_START = core_pkg::HS_START,
    parameter int HS_WIDTH = core_pkg::HS_WIDTH,
    parameter int V_ACTIVE = core_pkg::V_ACTIVE,
    parameter int V_TOTAL  = core_pkg::V_TOTAL,
    parameter int VS_START = core_pkg::VS_START,
    parameter int VS_WIDTH = core_pkg::VS_WIDTH,
    parameter int CEN_DIV  = core_pkg::CEN_DIV
) (
    input  wire logic             clk50,
    input  wire logic             rst_n,
    input  wire core_pkg::pix_t   scroll_x,
    input  wire core_pkg::mode_t  mode,
    input  wire logic             pal_we,
    input  wire core_pkg::cidx_t  pal_addr,
    input  wire core_pkg::rgb_t   pal_data,
    output logic                  vga_ce,
    output logic [7:0]            vga_r,
    output logic [7:0]            vga_g,
    output logic [7:0]            vga_b,
    output logic                  vga_hs,
    output logic                  vga_vs,
    output logic                  vga_de,
    output logic                  led_user,
    output logic [31:0]           frame_cnt
);

    import core_pkg::*;

    // Raster timing
    logic  pix_cen;
    pix_t  hcount;
    pix_t  vcount;
    logic  hs_raw;
    logic  vs_raw;
    logic  act_raw;

    // Per-frame settings
    pix_t  scroll_q;
    mode_t mode_q;
    logic  disp_en;

    // First pipeline stage
    cidx_t cidx;
    logic  de_d;
    logic  hs_d;
    logic  vs_d;
    logic  ce_d;

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .HS_START (HS_START),
        .HS_WIDTH (HS_WIDTH),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .VS_START (VS_START),
        .VS_WIDTH (VS_WIDTH),
        .CEN_DIV  (CEN_DIV)
    ) u_timing (
        .clk50   (clk50),
        .rst_n   (rst_n),
        .pix_cen (pix_cen),
        .hcount  (hcount),
        .vcount  (vcount),
        .hs_raw  (hs_raw),
        .vs_raw  (vs_raw),
        .act_raw (act_raw)
    );

    frame_ctrl u_ctrl (
        .clk50     (clk50),
        .rst_n     (rst_n),
        .vs_raw    (vs_raw),
        .act_raw   (act_raw),
        .scroll_x  (scroll_x),
        .mode      (mode),
        .scroll_q  (scroll_q),
        .mode_q    (mode_q),
        .disp_en   (disp_en),
        .frame_cnt (frame_cnt),
        .led_user  (led_user)
    );

    pattern_gen u_pattern (
        .clk50    (clk50),
        .rst_n    (rst_n),
        .hcount   (hcount),
        .vcount   (vcount),
        .scroll_q (scroll_q),
        .mode_q   (mode_q),
        .act_raw  (act_raw),
        .hs_raw   (hs_raw),
        .vs_raw   (vs_raw),
        .pix_cen  (pix_cen),
        .disp_en  (disp_en),
        .cidx     (cidx),
        .de_d     (de_d),
        .hs_d     (hs_d),
        .vs_d     (vs_d),
        .ce_d     (ce_d)
    );

    color_lut u_lut (
        .clk50    (clk50),
        .rst_n    (rst_n),
        .cidx     (cidx),
        .de_d     (de_d),
        .hs_d     (hs_d),
        .vs_d     (vs_d),
        .ce_d     (ce_d),
        .pal_we   (pal_we),
        .pal_addr (pal_addr),
        .pal_data (pal_data),
        .vga_r    (vga_r),
        .vga_g    (vga_g),
        .vga_b    (vga_b),
        .vga_de   (vga_de),
        .vga_hs   (vga_hs),
        .vga_vs   (vga_vs),
        .vga_ce   (vga_ce)
    );

endmodule

`default_nettype wire

//--- video_checker.sv
`default_nettype none

module video_checker #(
    parameter int H_TOTAL  = core_pkg::H_TOTAL,
    parameter int V_ACTIVE = core_pkg::V_ACTIVE,
    parameter int V_TOTAL  = core_pkg::V_TOTAL
) (
    input  wire logic            clk50,
    input  wire logic            rst_n,
    input  wire logic            pix_cen,
    input  wire core_pkg::pix_t  hcount,
    input  wire core_pkg::pix_t  vcount,
    input  wire logic            hs_raw,
    input  wire logic            vs_raw,
    input  wire logic            act_raw
);

    // Pixel enable is a one-clock pulse
    pix_cen_single: assert property (
        @(posedge clk50) disable iff (!rst_n) pix_cen |=> !pix_cen
    ) else $error("pix_cen stayed high for two consecutive cycles");

    // Horizontal sync lies in the blanking interval
    hs_outside_active: assert property (
        @(posedge clk50) disable iff (!rst_n) !(hs_raw && act_raw)
    ) else $error("hs_raw high inside the active area");

    // Vertical sync only on blank lines
    vs_outside_active: assert property (
        @(posedge clk50) disable iff (!rst_n) vs_raw |-> (int'(vcount) >= V_ACTIVE)
    ) else $error("vs_raw high on an active line");

    hcount_in_range: assert property (
        @(posedge clk50) disable iff (!rst_n) int'(hcount) < H_TOTAL
    ) else $error("hcount reached H_TOTAL");

    vcount_in_range: assert property (
        @(posedge clk50) disable iff (!rst_n) int'(vcount) < V_TOTAL
    ) else $error("vcount reached V_TOTAL");

endmodule

`default_nettype wire

//--- tb_top.sv
`default_nettype none

module tb_top;

    import core_pkg::*;

    localparam int NUM_FRAMES    = 10;
    localparam int FRAME_CLKS    = H_TOTAL * V_TOTAL * CEN_DIV;
    localparam int WATCHDOG_TIME = 12 * FRAME_CLKS * 20 + 2000;
    localparam int FRAME_PIXELS  = H_ACTIVE * V_ACTIVE;

    logic        clk50;
    logic        rst_n;
    pix_t        scroll_x;
    mode_t       mode;
    logic        pal_we;
    cidx_t       pal_addr;
    rgb_t        pal_data;
    logic        vga_ce;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_de;
    logic        led_user;
    logic [31:0] frame_cnt;

    // Reference model state
    integer seed;
    rgb_t   model_pal [16];
    pix_t   model_scroll;
    mode_t  model_mode;
    int     frames;
    int     pix_k;
    int     line_px;
    int     line_cnt;
    int     hs_ce;
    logic   vs_prev;
    logic   de_prev;
    logic   hs_prev;

    retro_video_core #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .HS_START (HS_START),
        .HS_WIDTH (HS_WIDTH),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .VS_START (VS_START),
        .VS_WIDTH (VS_WIDTH),
        .CEN_DIV  (CEN_DIV)
    ) DUT (
        .clk50     (clk50),
        .rst_n     (rst_n),
        .scroll_x  (scroll_x),
        .mode      (mode),
        .pal_we    (pal_we),
        .pal_addr  (pal_addr),
        .pal_data  (pal_data),
        .vga_ce    (vga_ce),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs),
        .vga_de    (vga_de),
        .led_user  (led_user),
        .frame_cnt (frame_cnt)
    );

    bind video_timing video_checker #(
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_checker (
        .clk50   (clk50),
        .rst_n   (rst_n),
        .pix_cen (pix_cen),
        .hcount  (hcount),
        .vcount  (vcount),
        .hs_raw  (hs_raw),
        .vs_raw  (vs_raw),
        .act_raw (act_raw)
    );

    initial clk50 = 1'b0;
    always #10 clk50 = ~clk50;

    // Index rules per mode for an already scrolled x
    function automatic cidx_t pattern_index(input int x, input int y, input mode_t m);
        case (m)
            2'd0:    return cidx_t'((x >> 2) & 15);
            2'd1:    return cidx_t'((y >> 1) & 15);
            2'd2:    return cidx_t'((x ^ y) & 15);
            default: return cidx_t'((x + y) & 15);
        endcase
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            fail_now($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Check the outputs on a falling edge, then drive new inputs
    task automatic monitor_and_drive();
        rgb_t exp_rgb;
        int   x;
        int   y;

        // Nothing shown before the first frame boundary
        if (frames == 0) begin
            expect_equal("vga_de", 32'(vga_de), 32'd0);
            expect_equal("led_user", 32'(led_user), 32'd0);
        end
        if (!vga_de) begin
            expect_equal("rgb", 32'({vga_r, vga_g, vga_b}), 32'd0);
        end

        if (vga_vs && !vs_prev) begin
            if (frames > 0) begin
                expect_equal("lines per frame", 32'(line_cnt), 32'(V_ACTIVE));
            end
            frames++;
            expect_equal("frame_cnt", frame_cnt, 32'(frames));
            expect_equal("led_user", 32'(led_user), 32'(frames[3]));
            model_scroll = scroll_x;
            model_mode   = mode;
        end
        if (!vga_vs && vs_prev) begin
            pix_k    = 0;
            line_cnt = 0;
        end

        if (vga_de) begin
            x       = ((pix_k % H_ACTIVE) + int'(model_scroll)) % 256;
            y       = pix_k / H_ACTIVE;
            exp_rgb = model_pal[pattern_index(x, y, model_mode)];
            expect_equal("rgb", 32'({vga_r, vga_g, vga_b}), 32'(exp_rgb));
            expect_equal("frame_cnt", frame_cnt, 32'(frames));
            expect_equal("led_user", 32'(led_user), 32'(frames[3]));
            if (vga_ce) begin
                pix_k++;
                line_px++;
            end
        end
        if (!vga_de && de_prev) begin
            expect_equal("pixels per line", 32'(line_px), 32'(H_ACTIVE));
            line_px = 0;
            line_cnt++;
        end

        if (vga_hs && vga_ce) begin
            hs_ce++;
        end
        if (!vga_hs && hs_prev) begin
            expect_equal("hsync width", 32'(hs_ce), 32'(HS_WIDTH));
            hs_ce = 0;
        end

        vs_prev = vga_vs;
        de_prev = vga_de;
        hs_prev = vga_hs;

        // Palette is only rewritten during vsync
        pal_we = 1'b0;
        if (vga_vs && (($random(seed) & 3) == 0)) begin
            pal_we   = 1'b1;
            pal_addr = cidx_t'($random(seed));
            pal_data = rgb_t'($random(seed));
            model_pal[pal_addr] = pal_data;
        end

        // Mid-frame changes that the picture must ignore
        if (vga_de && (($random(seed) & 63) == 0)) begin
            scroll_x = pix_t'($random(seed));
            mode     = mode_t'($random(seed));
        end
        // Pick new settings after the last pixel so the modes rotate
        if (vga_de && vga_ce && pix_k == FRAME_PIXELS) begin
            scroll_x = pix_t'($random(seed));
            mode     = mode_t'(frames);
        end
    endtask

    initial begin
        seed         = 13293;
        rst_n        = 1'b0;
        scroll_x     = pix_t'($random(seed));
        mode         = mode_t'($random(seed));
        pal_we       = 1'b0;
        pal_addr     = '0;
        pal_data     = '0;
        model_scroll = '0;
        model_mode   = '0;
        frames       = 0;
        pix_k        = 0;
        line_px      = 0;
        line_cnt     = 0;
        hs_ce        = 0;
        vs_prev      = 1'b0;
        de_prev      = 1'b0;
        hs_prev      = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model_pal[i] = '0;
        end

        for (int i = 0; i < 10; i++) begin
            @(negedge clk50);
            monitor_and_drive();
        end
        rst_n = 1'b1;

        while (frames < NUM_FRAMES) begin
            @(negedge clk50);
            monitor_and_drive();
        end

        $display("TB PASSED");
        $finish;
    end

    // Watchdog sized for twelve full frames
    initial begin
        #(WATCHDOG_TIME);
        fail_now($sformatf("Timeout after %0d time units with only %0d frames seen",
                           WATCHDOG_TIME, frames));
    end

endmodule

`default_nettype wire

//--- files.f
core_pkg.sv
video_timing.sv
frame_ctrl.sv
pattern_gen.sv
color_lut.sv
retro_video_core.sv
video_checker.sv
tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_top -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TB PASSED" sim.log; then
    echo "Simulation did not complete"
    exit 1
fi
echo "Simulation passed"
